/* common/rv32i_types_pkg.sv */
// Base RV32I types for the data word, double word, instruction address and CSR address
package rv32i_types_pkg;

  // Machine word width of the RV32 core
  localparam int WORD_W = 32;

  // Width of a CSR address field in the SYSTEM instructions
  localparam int CSR_ADDR_W = 12;

  // Plain data word that also holds CSR contents
  typedef logic [WORD_W-1:0] word_t;

  // Double word for the 64-bit counters
  typedef logic [2*WORD_W-1:0] dword_t;

  // Instruction address as seen by the fetch stage
  typedef word_t addr_t;

  // CSR address carried by CSRRW, CSRRS and CSRRC
  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

endpackage

/* common/machine_mode_types_pkg.sv */
// Machine-mode CSR addresses, register layouts, cause codes and MISA encodings
package machine_mode_types_pkg;
  import rv32i_types_pkg::*;

  // Machine information registers
  localparam csr_addr_t MVENDORID_ADDR = 12'hF11;
  localparam csr_addr_t MARCHID_ADDR   = 12'hF12;
  localparam csr_addr_t MIMPID_ADDR    = 12'hF13;
  localparam csr_addr_t MHARTID_ADDR   = 12'hF14;

  // Machine trap setup
  localparam csr_addr_t MSTATUS_ADDR   = 12'h300;
  localparam csr_addr_t MISA_ADDR      = 12'h301;
  localparam csr_addr_t MEDELEG_ADDR   = 12'h302;
  localparam csr_addr_t MIDELEG_ADDR   = 12'h303;
  localparam csr_addr_t MIE_ADDR       = 12'h304;
  localparam csr_addr_t MTVEC_ADDR     = 12'h305;

  // Machine trap handling
  localparam csr_addr_t MSCRATCH_ADDR  = 12'h340;
  localparam csr_addr_t MEPC_ADDR      = 12'h341;
  localparam csr_addr_t MCAUSE_ADDR    = 12'h342;
  localparam csr_addr_t MTVAL_ADDR     = 12'h343;
  localparam csr_addr_t MIP_ADDR       = 12'h344;

  // Machine counters as low and high halves
  localparam csr_addr_t MCYCLE_ADDR    = 12'hB00;
  localparam csr_addr_t MINSTRET_ADDR  = 12'hB02;
  localparam csr_addr_t MCYCLEH_ADDR   = 12'hB80;
  localparam csr_addr_t MINSTRETH_ADDR = 12'hB82;

  // Machine-mode privilege level encoding
  localparam logic [1:0] M_LEVEL = 2'b11;

  // mstatus with only the machine fields named
  typedef struct packed {
    logic [18:0] reserved_hi;
    logic [1:0]  mpp;
    logic [2:0]  reserved_mid;
    logic        mpie;
    logic [2:0]  reserved_lo;
    logic        mie;
    logic [2:0]  reserved_0;
  } mstatus_t;

  // Interrupt enables with the machine bits at 11, 7 and 3
  typedef struct packed {
    logic [19:0] reserved_3;
    logic        meie;
    logic [2:0]  reserved_2;
    logic        mtie;
    logic [2:0]  reserved_1;
    logic        msie;
    logic [2:0]  reserved_0;
  } mie_t;

  // Interrupt pending in the same layout as mie
  typedef struct packed {
    logic [19:0] reserved_3;
    logic        meip;
    logic [2:0]  reserved_2;
    logic        mtip;
    logic [2:0]  reserved_1;
    logic        msip;
    logic [2:0]  reserved_0;
  } mip_t;

  typedef struct packed {
    logic [29:0] base;
    logic [1:0]  mode;
  } mtvec_t;

  typedef struct packed {
    logic        interrupt;
    logic [30:0] cause;
  } mcause_t;

  typedef struct packed {
    logic [1:0]  base;
    logic [3:0]  zero;
    logic [25:0] extensions;
  } misa_t;

  // Synchronous exception codes
  typedef enum logic [3:0] {
    EX_INSN_MISALIGNED = 4'd0,
    EX_ILLEGAL_INSN    = 4'd2,
    EX_BREAKPOINT      = 4'd3,
    EX_LOAD_FAULT      = 4'd5,
    EX_STORE_FAULT     = 4'd7,
    EX_ECALL_M         = 4'd11
  } ex_cause_t;

  // Machine interrupt codes
  typedef enum logic [3:0] {
    SOFT_INT_M  = 4'd3,
    TIMER_INT_M = 4'd7,
    EXT_INT_M   = 4'd11
  } int_cause_t;

  // MISA base and extension letters
  localparam logic [1:0]  BASE_RV32  = 2'b01;
  localparam logic [25:0] MISA_EXT_E = 26'h000_0010;
  localparam logic [25:0] MISA_EXT_I = 26'h000_0100;
  localparam misa_t MISA_RESET = '{base: BASE_RV32, zero: 4'b0000, extensions: MISA_EXT_I};

endpackage

/* priv/priv_csr_rfile.sv */
// Machine-mode CSR register file with read decode, swap/set/clear update and counters
`timescale 1ns/1ps

module priv_csr_rfile
  import rv32i_types_pkg::*;
  import machine_mode_types_pkg::*;
#(
  parameter word_t HART_ID = 32'd0
) (
  input  logic      CLK,
  input  logic      nRST,
  input  csr_addr_t addr,
  input  word_t     wdata,
  input  logic      swap,
  input  logic      clr,
  input  logic      set,
  input  logic      valid_write,
  input  logic      instr_retired,
  input  logic      mstatus_rup,
  input  mstatus_t  mstatus_next,
  input  logic      mepc_rup,
  input  word_t     mepc_next,
  input  logic      mcause_rup,
  input  mcause_t   mcause_next,
  input  logic      mtval_rup,
  input  word_t     mtval_next,
  input  mip_t      mip_next,
  output word_t     rdata,
  output logic      invalid_csr,
  output mstatus_t  mstatus,
  output mie_t      mie,
  output mip_t      mip,
  output mtvec_t    mtvec,
  output word_t     mepc
);

  // Only the machine bits of mstatus, mie and mip are stored
  logic     st_mie;
  logic     st_mpie;
  logic     ie_meie;
  logic     ie_mtie;
  logic     ie_msie;
  logic     ip_meip;
  logic     ip_mtip;
  logic     ip_msip;
  misa_t    misa;
  word_t    mscratch;
  mcause_t  mcause;
  word_t    mtval;
  dword_t   cycle_cnt;
  dword_t   instret_cnt;

  logic     csr_op;
  logic     valid_addr;
  logic     wr_en;
  word_t    rup_data;
  mstatus_t rup_status;
  mie_t     rup_ie;
  misa_t    rup_misa;
  logic     misa_legal;

  // Rebuild the architectural views from the stored bits
  always_comb begin
    mstatus      = '0;
    mstatus.mpp  = M_LEVEL;
    mstatus.mpie = st_mpie;
    mstatus.mie  = st_mie;
    mie          = '0;
    mie.meie     = ie_meie;
    mie.mtie     = ie_mtie;
    mie.msie     = ie_msie;
    mip          = '0;
    mip.meip     = ip_meip;
    mip.mtip     = ip_mtip;
    mip.msip     = ip_msip;
  end

  assign csr_op      = swap | clr | set;
  assign invalid_csr = csr_op & ~valid_addr;
  // Unknown addresses never write
  assign wr_en       = csr_op & valid_addr & valid_write;

  assign rup_data = swap ? wdata :
                    clr  ? (rdata & ~wdata) :
                    set  ? (rdata | wdata) :
                    rdata;

  assign rup_status = mstatus_t'(rup_data);
  assign rup_ie     = mie_t'(rup_data);
  assign rup_misa   = misa_t'(rup_data);

  // Legal only with a base, a clear zero field and exactly one of I and E
  assign misa_legal = (rup_misa.base != 2'b00) && (rup_misa.zero == 4'b0000) &&
                      ((|(rup_misa.extensions & MISA_EXT_I)) ^
                       (|(rup_misa.extensions & MISA_EXT_E)));

  // Trap setup and handling registers where hardware updates come first
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      st_mie   <= 1'b0;
      st_mpie  <= 1'b0;
      ie_meie  <= 1'b0;
      ie_mtie  <= 1'b0;
      ie_msie  <= 1'b0;
      misa     <= MISA_RESET;
      mtvec    <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mtval    <= '0;
    end else begin
      if (mstatus_rup) begin
        st_mie  <= mstatus_next.mie;
        st_mpie <= mstatus_next.mpie;
      end else if (wr_en && (addr == MSTATUS_ADDR)) begin
        st_mie  <= rup_status.mie;
        st_mpie <= rup_status.mpie;
      end
      if (wr_en && (addr == MIE_ADDR)) begin
        ie_meie <= rup_ie.meie;
        ie_mtie <= rup_ie.mtie;
        ie_msie <= rup_ie.msie;
      end
      if (wr_en && (addr == MISA_ADDR) && misa_legal) begin
        misa <= rup_misa;
      end
      if (wr_en && (addr == MTVEC_ADDR)) begin
        mtvec <= mtvec_t'(rup_data);
      end
      if (wr_en && (addr == MSCRATCH_ADDR)) begin
        mscratch <= rup_data;
      end
      if (mepc_rup) begin
        mepc <= mepc_next;
      end else if (wr_en && (addr == MEPC_ADDR)) begin
        mepc <= rup_data;
      end
      if (mcause_rup) begin
        mcause <= mcause_next;
      end else if (wr_en && (addr == MCAUSE_ADDR)) begin
        mcause <= mcause_t'(rup_data);
      end
      if (mtval_rup) begin
        mtval <= mtval_next;
      end else if (wr_en && (addr == MTVAL_ADDR)) begin
        mtval <= rup_data;
      end
    end
  end

  // Interrupt lines sampled every cycle and the free-running counters
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ip_meip     <= 1'b0;
      ip_mtip     <= 1'b0;
      ip_msip     <= 1'b0;
      cycle_cnt   <= '0;
      instret_cnt <= '0;
    end else begin
      ip_meip     <= mip_next.meip;
      ip_mtip     <= mip_next.mtip;
      ip_msip     <= mip_next.msip;
      cycle_cnt   <= cycle_cnt + 64'd1;
      instret_cnt <= instret_cnt + dword_t'(instr_retired);
    end
  end

  // Read mux and address check
  always_comb begin
    valid_addr = 1'b1;
    case (addr)
      MVENDORID_ADDR, MARCHID_ADDR, MIMPID_ADDR: rdata = '0;
      MHARTID_ADDR:   rdata = HART_ID;
      MISA_ADDR:      rdata = word_t'(misa);
      MSTATUS_ADDR:   rdata = word_t'(mstatus);
      MEDELEG_ADDR, MIDELEG_ADDR: rdata = '0;
      MIE_ADDR:       rdata = word_t'(mie);
      MTVEC_ADDR:     rdata = word_t'(mtvec);
      MSCRATCH_ADDR:  rdata = mscratch;
      MEPC_ADDR:      rdata = mepc;
      MCAUSE_ADDR:    rdata = word_t'(mcause);
      MTVAL_ADDR:     rdata = mtval;
      MIP_ADDR:       rdata = word_t'(mip);
      MCYCLE_ADDR:    rdata = cycle_cnt[31:0];
      MCYCLEH_ADDR:   rdata = cycle_cnt[63:32];
      MINSTRET_ADDR:  rdata = instret_cnt[31:0];
      MINSTRETH_ADDR: rdata = instret_cnt[63:32];
      default: begin
        valid_addr = 1'b0;
        rdata      = '0;
      end
    endcase
  end

endmodule

/* priv/priv_trap_control.sv */
// Machine trap controller with pending interrupts, priority, cause, mstatus stack and redirect
`timescale 1ns/1ps

module priv_trap_control
  import rv32i_types_pkg::*;
  import machine_mode_types_pkg::*;
(
  input  mstatus_t  mstatus,
  input  mie_t      mie,
  input  mip_t      mip,
  input  mtvec_t    mtvec,
  input  word_t     mepc,
  input  logic      exception,
  input  ex_cause_t ex_cause,
  input  addr_t     ex_pc,
  input  word_t     ex_tval,
  input  addr_t     current_pc,
  input  logic      mret,
  input  logic      ext_int,
  input  logic      timer_int,
  input  logic      soft_int,
  output logic      trap_taken,
  output logic      mret_taken,
  output addr_t     insert_pc,
  output logic      mstatus_rup,
  output mstatus_t  mstatus_next,
  output logic      mepc_rup,
  output word_t     mepc_next,
  output logic      mcause_rup,
  output mcause_t   mcause_next,
  output logic      mtval_rup,
  output word_t     mtval_next,
  output mip_t      mip_next
);

  // Ordered as external, timer and software
  logic [2:0] int_ready;
  logic       int_taken;
  addr_t      trap_vector;

  // Raw lines go straight into mip and act one cycle later
  always_comb begin
    mip_next      = '0;
    mip_next.meip = ext_int;
    mip_next.mtip = timer_int;
    mip_next.msip = soft_int;
  end

  // Pending and enabled interrupts gated by the global enable
  assign int_ready = {mip.meip & mie.meie, mip.mtip & mie.mtie, mip.msip & mie.msie} &
                     {3{mstatus.mie}};
  assign int_taken  = |int_ready;

  assign trap_taken = exception | int_taken;
  // A trap in the same cycle overrides the return
  assign mret_taken = mret & ~trap_taken;

  // Exception first and then external, timer and software
  always_comb begin
    mcause_next = '0;
    if (exception) begin
      mcause_next.interrupt = 1'b0;
      mcause_next.cause     = 31'(ex_cause);
    end else if (int_ready[2]) begin
      mcause_next.interrupt = 1'b1;
      mcause_next.cause     = 31'(EXT_INT_M);
    end else if (int_ready[1]) begin
      mcause_next.interrupt = 1'b1;
      mcause_next.cause     = 31'(TIMER_INT_M);
    end else if (int_ready[0]) begin
      mcause_next.interrupt = 1'b1;
      mcause_next.cause     = 31'(SOFT_INT_M);
    end
  end

  assign mcause_rup = trap_taken;

  // Faulting pc for exceptions and interrupted pc otherwise
  assign mepc_rup   = trap_taken;
  assign mepc_next  = exception ? ex_pc : current_pc;

  assign mtval_rup  = trap_taken;
  assign mtval_next = exception ? ex_tval : '0;

  // Push the interrupt-enable stack on a trap and pop it on mret
  always_comb begin
    mstatus_next = mstatus;
    if (trap_taken) begin
      mstatus_next.mpie = mstatus.mie;
      mstatus_next.mie  = 1'b0;
    end else if (mret) begin
      mstatus_next.mie  = mstatus.mpie;
      mstatus_next.mpie = 1'b1;
    end
  end

  assign mstatus_rup = trap_taken | mret;

  // In direct mode every trap enters at the base
  assign trap_vector = {mtvec.base, 2'b00};

  assign insert_pc = trap_taken ? trap_vector :
                     mret_taken ? mepc :
                     '0;

endmodule

/* priv/priv_block.sv */
// Machine-mode privilege unit top with the CSR register file and the trap controller
`timescale 1ns/1ps

module priv_block
  import rv32i_types_pkg::*;
  import machine_mode_types_pkg::*;
#(
  parameter word_t HART_ID = 32'd0
) (
  input  logic      CLK,
  input  logic      nRST,
  input  csr_addr_t addr,
  input  word_t     wdata,
  input  logic      swap,
  input  logic      clr,
  input  logic      set,
  input  logic      valid_write,
  input  logic      instr_retired,
  input  logic      exception,
  input  ex_cause_t ex_cause,
  input  addr_t     ex_pc,
  input  word_t     ex_tval,
  input  addr_t     current_pc,
  input  logic      mret,
  input  logic      ext_int,
  input  logic      timer_int,
  input  logic      soft_int,
  output word_t     rdata,
  output logic      invalid_csr,
  output logic      trap_taken,
  output logic      mret_taken,
  output addr_t     insert_pc
);

  // Register state seen by the trap controller
  mstatus_t mstatus;
  mie_t     mie;
  mip_t     mip;
  mtvec_t   mtvec;
  word_t    mepc;

  // Hardware updates back into the register file
  logic     mstatus_rup;
  mstatus_t mstatus_next;
  logic     mepc_rup;
  word_t    mepc_next;
  logic     mcause_rup;
  mcause_t  mcause_next;
  logic     mtval_rup;
  word_t    mtval_next;
  mip_t     mip_next;

  priv_csr_rfile #(
    .HART_ID(HART_ID)
  ) csr_rfile_i (
    .CLK          (CLK),
    .nRST         (nRST),
    .addr         (addr),
    .wdata        (wdata),
    .swap         (swap),
    .clr          (clr),
    .set          (set),
    .valid_write  (valid_write),
    .instr_retired(instr_retired),
    .mstatus_rup  (mstatus_rup),
    .mstatus_next (mstatus_next),
    .mepc_rup     (mepc_rup),
    .mepc_next    (mepc_next),
    .mcause_rup   (mcause_rup),
    .mcause_next  (mcause_next),
    .mtval_rup    (mtval_rup),
    .mtval_next   (mtval_next),
    .mip_next     (mip_next),
    .rdata        (rdata),
    .invalid_csr  (invalid_csr),
    .mstatus      (mstatus),
    .mie          (mie),
    .mip          (mip),
    .mtvec        (mtvec),
    .mepc         (mepc)
  );

  priv_trap_control trap_control_i (
    .mstatus     (mstatus),
    .mie         (mie),
    .mip         (mip),
    .mtvec       (mtvec),
    .mepc        (mepc),
    .exception   (exception),
    .ex_cause    (ex_cause),
    .ex_pc       (ex_pc),
    .ex_tval     (ex_tval),
    .current_pc  (current_pc),
    .mret        (mret),
    .ext_int     (ext_int),
    .timer_int   (timer_int),
    .soft_int    (soft_int),
    .trap_taken  (trap_taken),
    .mret_taken  (mret_taken),
    .insert_pc   (insert_pc),
    .mstatus_rup (mstatus_rup),
    .mstatus_next(mstatus_next),
    .mepc_rup    (mepc_rup),
    .mepc_next   (mepc_next),
    .mcause_rup  (mcause_rup),
    .mcause_next (mcause_next),
    .mtval_rup   (mtval_rup),
    .mtval_next  (mtval_next),
    .mip_next    (mip_next)
  );

endmodule

/* sim/priv_checks.svh */
// Compare tasks for word, flag and cause results, and the routine that ends a failed run
`ifndef PRIV_CHECKS_SVH
`define PRIV_CHECKS_SVH

  // Final report for any failure
  task automatic stop_run();
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Failures that are not a wrong value
  task automatic fail_run(input string reason);
    $display("ERROR at time %0t: %s", $time, reason);
    stop_run();
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH time=%0t signal=%s expected=%b actual=%b", $time, name, exp, act);
      stop_run();
    end
  endtask

  // Shows the interrupt bit and the code apart
  task automatic check_cause(input string name, input mcause_t exp, input mcause_t act);
    if (act !== exp) begin
      $display("MISMATCH time=%0t signal=%s expected=%b/%0d actual=%b/%0d", $time, name,
               exp.interrupt, exp.cause, act.interrupt, act.cause);
      stop_run();
    end
  endtask

`endif

/* sim/priv_block_tb.sv */
// Privilege unit testbench with clock, reset, case file reader, stimulus and run sequence
`timescale 1ns/1ps

module priv_block_tb
  import rv32i_types_pkg::*;
  import machine_mode_types_pkg::*;
();

  localparam word_t HART_ID      = 32'h0000_0003;
  localparam int    TRAP_TIMEOUT = 8;

  logic      CLK;
  logic      nRST;
  csr_addr_t addr;
  word_t     wdata;
  logic      swap;
  logic      clr;
  logic      set;
  logic      valid_write;
  logic      instr_retired;
  logic      exception;
  ex_cause_t ex_cause;
  addr_t     ex_pc;
  word_t     ex_tval;
  addr_t     current_pc;
  logic      mret;
  logic      ext_int;
  logic      timer_int;
  logic      soft_int;
  word_t     rdata;
  logic      invalid_csr;
  logic      trap_taken;
  logic      mret_taken;
  addr_t     insert_pc;

  // Expected CSR contents filled in as values become known
  word_t  shadow [4096];
  bit     known [4096];
  integer seed;
  int     retired_count;

  priv_block #(.HART_ID(HART_ID)) dut_i (.*);

  `include "priv_checks.svh"

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // All strobes and interrupt lines idle while addr selects the CSR to read
  task automatic idle_inputs(input csr_addr_t a);
    addr          = a;
    wdata         = '0;
    swap          = 1'b0;
    clr           = 1'b0;
    set           = 1'b0;
    valid_write   = 1'b0;
    instr_retired = 1'b0;
    exception     = 1'b0;
    ex_cause      = EX_INSN_MISALIGNED;
    ex_pc         = '0;
    ex_tval       = '0;
    mret          = 1'b0;
    ext_int       = 1'b0;
    timer_int     = 1'b0;
    soft_int      = 1'b0;
  endtask

  task automatic next_cycle(input csr_addr_t a);
    @(negedge CLK);
    idle_inputs(a);
    #2;
  endtask

  task automatic read_expect(input string name, input csr_addr_t a, input word_t exp);
    next_cycle(a);
    check_word(name, exp, rdata);
    shadow[a] = exp;
    known[a]  = 1'b1;
  endtask

  task automatic csr_request(input logic s, input logic c, input logic w, input csr_addr_t a,
                             input word_t data, input logic wen);
    @(negedge CLK);
    idle_inputs(a);
    swap        = s;
    clr         = c;
    set         = w;
    wdata       = data;
    valid_write = wen;
    #2;
  endtask

  // Interrupt-enable stack push on trap entry
  function automatic word_t pushed_status(input word_t old);
    mstatus_t st;
    st      = mstatus_t'(old);
    st.mpie = st.mie;
    st.mie  = 1'b0;
    return word_t'(st);
  endfunction

  task automatic check_trap(input mcause_t cause, input addr_t pc, input word_t tval);
    word_t new_status;
    new_status = pushed_status(shadow[MSTATUS_ADDR]);
    check_flag("trap_taken", 1'b1, trap_taken);
    check_word("insert_pc", {shadow[MTVEC_ADDR][31:2], 2'b00}, insert_pc);
    next_cycle(MCAUSE_ADDR);
    check_cause("mcause", cause, mcause_t'(rdata));
    read_expect("mepc", MEPC_ADDR, pc);
    read_expect("mtval", MTVAL_ADDR, tval);
    read_expect("mstatus", MSTATUS_ADDR, new_status);
  endtask

  task automatic take_interrupt(input word_t lines, input addr_t pc, input word_t code);
    mcause_t cause;
    int      waited;
    cause.interrupt = 1'b1;
    cause.cause     = 31'(code);
    @(negedge CLK);
    idle_inputs(MCAUSE_ADDR);
    current_pc = pc;
    ext_int    = lines[2];
    timer_int  = lines[1];
    soft_int   = lines[0];
    #2;
    waited = 0;
    // Lines reach mip one cycle after they rise
    while (!trap_taken) begin
      if (waited == TRAP_TIMEOUT) fail_run("no trap taken after the interrupt lines rose");
      @(negedge CLK);
      #2;
      waited++;
    end
    check_trap(cause, pc, '0);
  endtask

  task automatic run_case(input logic [63:0] op, input csr_addr_t a, input word_t d,
                          input word_t pc, input word_t tv, input word_t ex);
    word_t   rnd;
    word_t   st;
    mcause_t cause;
    if ((op == "set" || op == "clr" || op == "nowr" || op == "same") && !known[a])
      fail_run("case needs a CSR value that no earlier case established");
    case (op)
      "rd": read_expect("rdata", a, ex);
      "same": read_expect("rdata", a, shadow[a]);
      "swap": begin
        csr_request(1'b1, 1'b0, 1'b0, a, d, 1'b1);
        check_flag("invalid_csr", 1'b0, invalid_csr);
        if (known[a]) check_word("rdata", shadow[a], rdata);
        read_expect("rdata", a, ex);
      end
      "set", "clr": begin
        rnd = $random(seed);
        csr_request(1'b0, op == "clr", op == "set", a, rnd, 1'b1);
        check_flag("invalid_csr", 1'b0, invalid_csr);
        check_word("rdata", shadow[a], rdata);
        if (op == "set") read_expect("rdata", a, (shadow[a] | rnd) & d);
        else read_expect("rdata", a, (shadow[a] & ~rnd) & d);
      end
      "nowr": begin
        csr_request(1'b1, 1'b0, 1'b0, a, d, 1'b0);
        read_expect("rdata", a, shadow[a]);
      end
      "inv": begin
        csr_request(1'b1, 1'b0, 1'b0, a, d, 1'b1);
        check_flag("invalid_csr", 1'b1, invalid_csr);
        check_word("rdata", '0, rdata);
        next_cycle(a);
        check_flag("invalid_csr", 1'b0, invalid_csr);
      end
      "exc": begin
        cause.interrupt = 1'b0;
        cause.cause     = 31'(d);
        @(negedge CLK);
        idle_inputs(MCAUSE_ADDR);
        exception = 1'b1;
        ex_cause  = ex_cause_t'(d[3:0]);
        ex_pc     = pc;
        ex_tval   = tv;
        #2;
        check_trap(cause, pc, tv);
      end
      "int": take_interrupt(d, pc, ex);
      "mret": begin
        st = shadow[MSTATUS_ADDR];
        // Pop sets mie from mpie and then sets mpie
        st[3] = st[7];
        st[7] = 1'b1;
        @(negedge CLK);
        idle_inputs(MSTATUS_ADDR);
        mret = 1'b1;
        #2;
        check_flag("mret_taken", 1'b1, mret_taken);
        check_flag("trap_taken", 1'b0, trap_taken);
        check_word("insert_pc", shadow[MEPC_ADDR], insert_pc);
        read_expect("mstatus", MSTATUS_ADDR, st);
      end
      "ret": begin
        for (int i = 0; i < d; i++) begin
          @(negedge CLK);
          idle_inputs(MINSTRET_ADDR);
          rnd           = $random(seed);
          instr_retired = rnd[0];
          retired_count = retired_count + rnd[0];
        end
      end
      "cnt": begin
        read_expect("minstret", MINSTRET_ADDR, word_t'(retired_count));
        read_expect("minstreth", MINSTRETH_ADDR, '0);
        next_cycle(MCYCLE_ADDR);
        rnd = rdata;
        next_cycle(MCYCLE_ADDR);
        check_word("mcycle", rnd + 32'd1, rdata);
      end
      default: fail_run("unknown operation in the case file");
    endcase
  endtask

  initial begin
    integer           fd;
    integer           n;
    logic [8*128-1:0] line_buf;
    logic [63:0]      op_name;
    csr_addr_t        a;
    word_t            d;
    word_t            pc;
    word_t            tv;
    word_t            ex;
    seed          = 36963;
    retired_count = 0;
    current_pc    = '0;
    nRST          = 1'b0;
    idle_inputs('0);
    repeat (3) @(negedge CLK);
    nRST = 1'b1;
    #2;
    check_flag("trap_taken", 1'b0, trap_taken);
    check_flag("mret_taken", 1'b0, mret_taken);
    check_flag("invalid_csr", 1'b0, invalid_csr);
    fd = $fopen("sim/priv_cases.txt", "r");
    if (fd == 0) fail_run("cannot open sim/priv_cases.txt");
    while ($fgets(line_buf, fd) > 0) begin
      n = $sscanf(line_buf, "%s %h %h %h %h %h", op_name, a, d, pc, tv, ex);
      if (n > 0 && op_name != "#") begin
        if (n != 6) fail_run("malformed line in the case file");
        run_case(op_name, a, d, pc, tv, ex);
      end
    end
    $fclose(fd);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* sim/priv_cases.txt */
# op   addr data     pc       tval     expected  (all hex, unused fields 0)
# data: wdata, writable mask for set/clr, cause, int lines {ext,timer,soft}, retire cycles
rd     300  00000000 00000000 00000000 00001800
rd     304  00000000 00000000 00000000 00000000
rd     305  00000000 00000000 00000000 00000000
rd     341  00000000 00000000 00000000 00000000
rd     340  00000000 00000000 00000000 00000000
rd     301  00000000 00000000 00000000 40000100
rd     f14  00000000 00000000 00000000 00000003
rd     302  00000000 00000000 00000000 00000000
swap   340  a5a55a5a 00000000 00000000 a5a55a5a
set    340  ffffffff 00000000 00000000 00000000
clr    340  ffffffff 00000000 00000000 00000000
swap   305  00000100 00000000 00000000 00000100
set    305  ffffffff 00000000 00000000 00000000
clr    305  ffffffff 00000000 00000000 00000000
swap   304  00000888 00000000 00000000 00000888
clr    304  00000888 00000000 00000000 00000000
set    304  00000888 00000000 00000000 00000000
nowr   340  cafef00d 00000000 00000000 00000000
inv    7c0  12345678 00000000 00000000 00000000
inv    3a0  ffffffff 00000000 00000000 00000000
same   340  00000000 00000000 00000000 00000000
swap   301  40000110 00000000 00000000 40000100
swap   301  44000100 00000000 00000000 40000100
swap   301  40000010 00000000 00000000 40000010
swap   301  40000100 00000000 00000000 40000100
swap   305  00000200 00000000 00000000 00000200
swap   304  00000000 00000000 00000000 00000000
swap   300  00000008 00000000 00000000 00001808
exc    000  00000002 00000420 00000013 00000000
mret   000  00000000 00000000 00000000 00000000
swap   304  00000080 00000000 00000000 00000080
int    000  00000002 00000500 00000000 00000007
mret   000  00000000 00000000 00000000 00000000
swap   304  00000888 00000000 00000000 00000888
int    000  00000007 00000600 00000000 0000000b
mret   000  00000000 00000000 00000000 00000000
ret    000  00000010 00000000 00000000 00000000
cnt    000  00000000 00000000 00000000 00000000

/* flist.f */
+incdir+sim
common/rv32i_types_pkg.sv
common/machine_mode_types_pkg.sv
priv/priv_csr_rfile.sv
priv/priv_trap_control.sv
priv/priv_block.sv
sim/priv_block_tb.sv
